/* gpio_pkg.sv */
// *******************
// GPIO subsystem package
// Register bus widths, register map and host count
// *******************
package gpio_pkg;

  // Register bus
  localparam int data_w = 32;  // Register data width
  localparam int addr_w = 5;   // Byte address, spans both peripherals
  localparam int strb_w = 4;   // Write strobe, any nonzero bit writes all

  // Peer host ports in front of the arbiter
  localparam int num_hosts = 2;

  // GPIO register block, offsets 0 to 8
  localparam logic [addr_w-1:0] reg_gpio_dir = 5'd0;  // Output enable, 1 = output
  localparam logic [addr_w-1:0] reg_gpio_out = 5'd4;  // Output values
  localparam logic [addr_w-1:0] reg_gpio_in  = 5'd8;  // Pin inputs, read only

  // Edge capture block, offsets 16 and 20
  localparam logic [addr_w-1:0] reg_edge_status = 5'd16;  // Sticky flags, W1C
  localparam logic [addr_w-1:0] reg_edge_mask   = 5'd20;  // Edge enable per pin

  // One queued request, packed as {addr, wstrb, wdata}
  localparam int req_w = addr_w + strb_w + data_w;

  // Field positions inside a request
  localparam int req_strb_lsb = data_w;
  localparam int req_addr_lsb = data_w + strb_w;

endpackage

/* cmd_queue.sv */
// *******************
// Host request queue
// Circular buffer, one credit back per freed entry
// *******************
`timescale 1ns/10ps

module cmd_queue
  import gpio_pkg::*;
#(
  parameter int queue_depth = 4  // Entries, also the host's initial credits
) (
  input  logic             clk,
  input  logic             resetn,
  input  logic             push,       // Host request, only while holding a credit
  input  logic [req_w-1:0] push_data,
  output logic             q_valid,    // Head entry present
  output logic [req_w-1:0] q_data,
  input  logic             q_pop,      // Interconnect took the head
  output logic             credit      // One cycle, one slot freed
);

  localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
  localparam int cnt_w = $clog2(queue_depth + 1);

  logic [req_w-1:0] mem [queue_depth];  // Request storage
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;  // Occupied entries

  // Pointer step with wrap, depth need not be a power of two
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    if (p == ptr_w'(queue_depth - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign q_valid = (count != '0);
  assign q_data  = mem[rd_ptr];  // Head shown combinationally

  // Payload write, credits keep the host off a full queue
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (q_pop) rd_ptr <= ptr_inc(rd_ptr);
      case ({push, q_pop})
        2'b10:   count <= count + 1'b1;  // Fill only
        2'b01:   count <= count - 1'b1;  // Drain only
        default: count <= count;         // Both or neither
      endcase
      credit <= q_pop;  // Pop at T, credit at T+1
    end
  end

endmodule

/* bus_interconnect.sv */
// *******************
// Register bus interconnect
// Round-robin host grant, address decode, response steering
// *******************
`timescale 1ns/10ps

module bus_interconnect
  import gpio_pkg::*;
(
  input  logic                            clk,
  input  logic                            resetn,
  input  logic [num_hosts-1:0]            q_valid,
  input  logic [num_hosts-1:0][req_w-1:0] q_data,
  output logic [num_hosts-1:0]            q_pop,
  output logic [addr_w-1:0]               bus_addr,
  output logic [strb_w-1:0]               bus_wrstb,
  output logic [data_w-1:0]               bus_wdata,
  output logic                            gpio_valid,
  input  logic                            gpio_ready,
  input  logic [data_w-1:0]               gpio_rdata,
  output logic                            edge_valid,
  input  logic                            edge_ready,
  input  logic [data_w-1:0]               edge_rdata,
  output logic [num_hosts-1:0]            rsp_valid,
  output logic [data_w-1:0]               rsp_rdata
);

  localparam int host_w = (num_hosts > 1) ? $clog2(num_hosts) : 1;

  logic [host_w-1:0] rr_ptr;     // First claim on the next grant
  logic [host_w-1:0] owner;      // Host of the transaction in flight
  logic              busy;       // High from T+1 until the response
  logic              unmap_ack;  // Self answer for unmapped offsets
  logic              found;      // Some queue holds a request
  logic [host_w-1:0] pick;       // Round-robin winner
  logic              grant;
  logic [req_w-1:0]  sel_req;
  logic              gpio_hit;
  logic              edge_hit;
  logic              rsp_any;

  // Scan the queues starting at rr_ptr
  always_comb begin
    int cand;
    found = 1'b0;
    pick  = '0;
    for (int i = 0; i < num_hosts; i++) begin
      cand = (int'(rr_ptr) + i) % num_hosts;
      if (!found && q_valid[cand]) begin
        found = 1'b1;
        pick  = host_w'(cand);
      end
    end
  end

  assign grant = found && !busy;  // One transaction at a time

  always_comb begin
    q_pop = '0;
    q_pop[pick] = grant;
  end

  // Shared bus fields from the winning head entry
  assign sel_req   = q_data[pick];
  assign bus_addr  = sel_req[req_addr_lsb +: addr_w];
  assign bus_wrstb = sel_req[req_strb_lsb +: strb_w];
  assign bus_wdata = sel_req[data_w-1:0];

  // Offsets 0..8 to GPIO, 16 and 20 to edge capture
  assign gpio_hit = (bus_addr <= reg_gpio_in);
  assign edge_hit = (bus_addr == reg_edge_status) || (bus_addr == reg_edge_mask);

  assign gpio_valid = grant && gpio_hit;
  assign edge_valid = grant && edge_hit;

  // Response at T+1, routed to the owner
  assign rsp_any   = gpio_ready || edge_ready || unmap_ack;
  assign rsp_rdata = gpio_ready ? gpio_rdata :
                     edge_ready ? edge_rdata : '0;  // Unmapped reads 0

  always_comb begin
    rsp_valid = '0;
    rsp_valid[owner] = rsp_any;
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      rr_ptr    <= '0;  // Host 0 first after reset
      owner     <= '0;
      busy      <= 1'b0;
      unmap_ack <= 1'b0;
    end else begin
      unmap_ack <= grant && !gpio_hit && !edge_hit;
      if (grant) begin
        busy  <= 1'b1;
        owner <= pick;
        if (pick == host_w'(num_hosts - 1)) rr_ptr <= '0;
        else rr_ptr <= pick + 1'b1;  // Winner goes to the back
      end else if (rsp_any) begin
        busy <= 1'b0;  // Idle again at T+2
      end
    end
  end

endmodule

/* gpio_port.sv */
// *******************
// GPIO register block
// Direction, output and input registers on the register bus
// *******************
`timescale 1ns/10ps

module gpio_port
  import gpio_pkg::*;
#(
  parameter int gpio_nr = 8  // Pin count, at most data_w
) (
  input  logic               clk,
  input  logic               resetn,
  input  logic [3:0]         addr,          // Local byte offset
  input  logic [strb_w-1:0]  wrstb,
  input  logic [data_w-1:0]  wdata,
  input  logic               valid,
  output logic               ready,         // One cycle after valid
  output logic [data_w-1:0]  rdata,
  input  logic [gpio_nr-1:0] gpio_in,       // Pad input values
  output logic [gpio_nr-1:0] gpio_out_en,   // 1 drives the pad
  output logic [gpio_nr-1:0] gpio_out_val
);

  // Local offsets inside the 16 byte window
  localparam logic [3:0] off_dir = reg_gpio_dir[3:0];
  localparam logic [3:0] off_out = reg_gpio_out[3:0];
  localparam logic [3:0] off_in  = reg_gpio_in[3:0];

  logic              wr;
  logic [data_w-1:0] rd_mux;

  assign wr = |wrstb;  // Whole register written, no byte lanes

  // Read data selection
  always_comb begin
    case (addr)
      off_dir: rd_mux = data_w'(gpio_out_en);
      off_out: rd_mux = data_w'(gpio_out_val);
      off_in:  rd_mux = data_w'(gpio_in);
      default: rd_mux = '0;  // Nothing stale on a hole
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready <= 1'b0;
    end else begin
      ready <= valid;
    end
  end

  // Pin control, all inputs out of reset
  always_ff @(posedge clk) begin
    if (!resetn) begin
      gpio_out_en  <= '0;
      gpio_out_val <= '0;
    end else if (valid && wr) begin
      case (addr)
        off_dir: gpio_out_en  <= wdata[gpio_nr-1:0];
        off_out: gpio_out_val <= wdata[gpio_nr-1:0];
        default: ;  // Input register is read only
      endcase
    end
  end

  // Read data, zero for writes
  always_ff @(posedge clk) begin
    if (valid) begin
      rdata <= wr ? '0 : rd_mux;
    end
  end

endmodule

/* edge_capture.sv */
// *******************
// Edge capture peripheral
// Sticky rising-edge flags under a mask, W1C, interrupt
// *******************
`timescale 1ns/10ps

module edge_capture
  import gpio_pkg::*;
#(
  parameter int gpio_nr = 8
) (
  input  logic               clk,
  input  logic               resetn,
  input  logic [3:0]         addr,     // Local byte offset
  input  logic [strb_w-1:0]  wrstb,
  input  logic [data_w-1:0]  wdata,
  input  logic               valid,
  output logic               ready,
  output logic [data_w-1:0]  rdata,
  input  logic [gpio_nr-1:0] gpio_in,
  output logic               irq       // Any flag set
);

  localparam logic [3:0] off_status = reg_edge_status[3:0];
  localparam logic [3:0] off_mask   = reg_edge_mask[3:0];

  logic [gpio_nr-1:0] prev_in;  // Last pin sample
  logic [gpio_nr-1:0] mask;
  logic [gpio_nr-1:0] status;
  logic [gpio_nr-1:0] rise;     // Masked 0 to 1 this cycle
  logic [gpio_nr-1:0] clr;      // Write-one-to-clear bits
  logic               wr;

  assign wr   = |wrstb;
  assign rise = gpio_in & ~prev_in & mask;
  assign clr  = (valid && wr && addr == off_status) ? wdata[gpio_nr-1:0] : '0;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      prev_in <= '0;
      mask    <= '0;
      status  <= '0;
      irq     <= 1'b0;
      ready   <= 1'b0;
    end else begin
      prev_in <= gpio_in;
      ready   <= valid;
      if (valid && wr && addr == off_mask) mask <= wdata[gpio_nr-1:0];
      status <= (status & ~clr) | rise;  // New edge wins over clear
      irq    <= |status;
    end
  end

  // Read data, holes and writes return 0
  always_ff @(posedge clk) begin
    if (valid) begin
      if (!wr && addr == off_status) rdata <= data_w'(status);
      else if (!wr && addr == off_mask) rdata <= data_w'(mask);
      else rdata <= '0;
    end
  end

endmodule

/* gpio_subsys.sv */
// *******************
// GPIO subsystem top level
// Two host queues, interconnect, GPIO and edge capture
// *******************
`timescale 1ns/10ps

module gpio_subsys
  import gpio_pkg::*;
#(
  parameter int gpio_nr     = 8,
  parameter int queue_depth = 4
) (
  input  logic               clk,
  input  logic               resetn,
  input  logic               h0_req_valid,
  input  logic [addr_w-1:0]  h0_req_addr,
  input  logic [strb_w-1:0]  h0_req_wstrb,
  input  logic [data_w-1:0]  h0_req_wdata,
  output logic               h0_req_credit,
  output logic               h0_rsp_valid,
  output logic [data_w-1:0]  h0_rsp_rdata,
  input  logic               h1_req_valid,
  input  logic [addr_w-1:0]  h1_req_addr,
  input  logic [strb_w-1:0]  h1_req_wstrb,
  input  logic [data_w-1:0]  h1_req_wdata,
  output logic               h1_req_credit,
  output logic               h1_rsp_valid,
  output logic [data_w-1:0]  h1_rsp_rdata,
  input  logic [gpio_nr-1:0] gpio_in,
  output logic [gpio_nr-1:0] gpio_out_en,
  output logic [gpio_nr-1:0] gpio_out_val,
  output logic               irq
);

  logic [num_hosts-1:0][req_w-1:0] q_data;
  logic [num_hosts-1:0]            q_valid;
  logic [num_hosts-1:0]            q_pop;
  logic [num_hosts-1:0]            rsp_valid;
  logic [data_w-1:0]               rsp_rdata;
  logic [addr_w-1:0]               bus_addr;
  logic [strb_w-1:0]               bus_wrstb;
  logic [data_w-1:0]               bus_wdata;
  logic                            gpio_valid, gpio_ready;
  logic [data_w-1:0]               gpio_rdata;
  logic                            edge_valid, edge_ready;
  logic [data_w-1:0]               edge_rdata;

  // Responses share one data bus, valid picks the host
  assign h0_rsp_valid = rsp_valid[0];
  assign h1_rsp_valid = rsp_valid[1];
  assign h0_rsp_rdata = rsp_rdata;
  assign h1_rsp_rdata = rsp_rdata;

  cmd_queue #(.queue_depth(queue_depth)) queue_h0 (
    .clk, .resetn,
    .push      (h0_req_valid),
    .push_data ({h0_req_addr, h0_req_wstrb, h0_req_wdata}),
    .q_valid   (q_valid[0]),
    .q_data    (q_data[0]),
    .q_pop     (q_pop[0]),
    .credit    (h0_req_credit)
  );

  cmd_queue #(.queue_depth(queue_depth)) queue_h1 (
    .clk, .resetn,
    .push      (h1_req_valid),
    .push_data ({h1_req_addr, h1_req_wstrb, h1_req_wdata}),
    .q_valid   (q_valid[1]),
    .q_data    (q_data[1]),
    .q_pop     (q_pop[1]),
    .credit    (h1_req_credit)
  );

  bus_interconnect ic_i (
    .clk, .resetn, .q_valid, .q_data, .q_pop,
    .bus_addr, .bus_wrstb, .bus_wdata,
    .gpio_valid, .gpio_ready, .gpio_rdata,
    .edge_valid, .edge_ready, .edge_rdata,
    .rsp_valid, .rsp_rdata
  );

  // Peripherals see the offset inside their 16 byte window
  gpio_port #(.gpio_nr(gpio_nr)) gpio_i (
    .clk, .resetn,
    .addr  (bus_addr[3:0]),
    .wrstb (bus_wrstb),
    .wdata (bus_wdata),
    .valid (gpio_valid),
    .ready (gpio_ready),
    .rdata (gpio_rdata),
    .gpio_in, .gpio_out_en, .gpio_out_val
  );

  edge_capture #(.gpio_nr(gpio_nr)) edge_i (
    .clk, .resetn,
    .addr  (bus_addr[3:0]),
    .wrstb (bus_wrstb),
    .wdata (bus_wdata),
    .valid (edge_valid),
    .ready (edge_ready),
    .rdata (edge_rdata),
    .gpio_in, .irq
  );

endmodule

/* tb_clock_gen.sv */
// *******************
// Testbench clock and reset
// 20 ns clock, reset held low for 16 cycles
// *******************
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk,
  output logic resetn
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  initial begin
    resetn = 1'b0;
    repeat (16) @(posedge clk);
    #2 resetn = 1'b1;  // Released off the edge, like the stimulus
  end

endmodule

/* gpio_subsys_assertions.sv */
// *******************
// GPIO subsystem bus checks
// Queue overflow, single bus transaction, response routing
// *******************
`timescale 1ns/10ps

module gpio_subsys_assertions
  import gpio_pkg::*;
#(
  parameter int queue_depth = 4
) (
  input logic                 clk,
  input logic                 resetn,
  input logic [num_hosts-1:0] push,        // Request accepted into queue h
  input logic [num_hosts-1:0] q_pop,
  input logic                 gpio_valid,
  input logic                 edge_valid,
  input logic [num_hosts-1:0] rsp_valid
);

  int fill [num_hosts];  // Shadow occupancy per queue

  always_ff @(posedge clk) begin
    for (int h = 0; h < num_hosts; h++) begin
      if (!resetn) fill[h] <= 0;
      else fill[h] <= fill[h] + int'(push[h]) - int'(q_pop[h]);
    end
  end

  for (genvar h = 0; h < num_hosts; h++) begin : g_queue
    no_overflow: assert property (@(posedge clk) disable iff (!resetn)
      push[h] |-> fill[h] < queue_depth)
      else $error("Host %0d pushed into a full request queue", h);
  end

  // One peripheral valid at a time, and none in the cycle after a valid
  single_target: assert property (@(posedge clk) disable iff (!resetn)
    $onehot0({gpio_valid, edge_valid, $past(gpio_valid || edge_valid)}))
    else $error("Two peripheral transactions overlap on the bus");

  // Response one cycle after the pop, on the popped host only
  single_rsp: assert property (@(posedge clk) disable iff (!resetn)
    $onehot0(rsp_valid) && rsp_valid == $past(q_pop))
    else $error("Response not on the host whose queue was popped one cycle earlier");

endmodule

/* gpio_subsys_tb.sv */
// *******************
// GPIO subsystem testbench
// Host models, pad loopback, directed tests
// *******************
`timescale 1ns/10ps

module gpio_subsys_tb
  import gpio_pkg::*;
;
  localparam int gpio_nr     = 8;
  localparam int queue_depth = 4;
  localparam int num_tests   = 6;

  logic clk, resetn;
  logic h0_req_valid, h1_req_valid;
  logic [addr_w-1:0] h0_req_addr, h1_req_addr;
  logic [strb_w-1:0] h0_req_wstrb, h1_req_wstrb;
  logic [data_w-1:0] h0_req_wdata, h1_req_wdata, h0_rsp_rdata, h1_rsp_rdata;
  logic h0_req_credit, h1_req_credit, h0_rsp_valid, h1_rsp_valid;
  logic [gpio_nr-1:0] gpio_in, gpio_out_en, gpio_out_val, pin_val;
  logic irq;
  logic [gpio_nr-1:0] cur_dir, cur_out;  // Last values written by the tests

  int sent [2];      // Requests pushed per host
  int returned [2];  // Credit pulses seen per host
  int rcvd [2];      // Responses seen per host
  logic [32:0] exp0 [$];  // {is_read, rdata} in request order
  logic [32:0] exp1 [$];

  tb_clock_gen clk_gen_i (.clk(clk), .resetn(resetn));

  gpio_subsys #(.gpio_nr(gpio_nr), .queue_depth(queue_depth)) dut_i (.*);

  bind gpio_subsys gpio_subsys_assertions #(.queue_depth(queue_depth)) checks_i (
    .clk(clk), .resetn(resetn), .push({h1_req_valid, h0_req_valid}), .q_pop(q_pop),
    .gpio_valid(gpio_valid), .edge_valid(edge_valid), .rsp_valid(rsp_valid)
  );

  // Pad: driven pins loop back, the rest follow the external value
  assign gpio_in = (gpio_out_en & gpio_out_val) | (~gpio_out_en & pin_val);

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check(input logic ok, input string what);
    assert (ok) else stop_run($sformatf("FAILED %0t: %s", $time, what));
  endtask

  function automatic int credits(input int h);
    return queue_depth - sent[h] + returned[h];
  endfunction

  // Response ordering, write data ignored
  task automatic take_rsp(input int h, input logic [data_w-1:0] data);
    logic [32:0] e;
    check(rcvd[h] < sent[h], $sformatf("host %0d response with none pending", h));
    e = (h == 0) ? exp0[rcvd[h]] : exp1[rcvd[h]];
    if (e[32]) check(data == e[31:0], $sformatf("host %0d read %h, expected %h", h, data, e[31:0]));
    rcvd[h] = rcvd[h] + 1;
  endtask

  always @(posedge clk) begin
    if (resetn) begin
      if (h0_rsp_valid) take_rsp(0, h0_rsp_rdata);
      if (h1_rsp_valid) take_rsp(1, h1_rsp_rdata);
      if (h0_req_credit) returned[0] = returned[0] + 1;
      if (h1_req_credit) returned[1] = returned[1] + 1;
      check(credits(0) <= queue_depth && credits(1) <= queue_depth, "credit without a pop");
    end
  end

  // One request, sent only while the host holds a credit
  task automatic send(input int h, input logic [addr_w-1:0] addr, input logic [strb_w-1:0] strb,
                      input logic [data_w-1:0] wdata, input logic [data_w-1:0] rd_exp);
    while (credits(h) == 0) begin
      @(posedge clk);
      #2;
    end
    if (h == 0) begin
      exp0.push_back({strb == '0, rd_exp});
      {h0_req_valid, h0_req_addr, h0_req_wstrb, h0_req_wdata} = {1'b1, addr, strb, wdata};
    end else begin
      exp1.push_back({strb == '0, rd_exp});
      {h1_req_valid, h1_req_addr, h1_req_wstrb, h1_req_wdata} = {1'b1, addr, strb, wdata};
    end
    sent[h] = sent[h] + 1;
    @(posedge clk);
    #2;
    if (h == 0) h0_req_valid = 1'b0;
    else h1_req_valid = 1'b0;
  endtask

  task automatic write_reg(input int h, input logic [addr_w-1:0] addr, input logic [data_w-1:0] v);
    send(h, addr, 4'hf, v, '0);
  endtask

  task automatic read_reg(input int h, input logic [addr_w-1:0] addr, input logic [data_w-1:0] v);
    send(h, addr, 4'h0, '0, v);
  endtask

  // All responses in and all credits home
  task automatic wait_idle();
    while (rcvd[0] != sent[0] || rcvd[1] != sent[1] || credits(0) != queue_depth ||
           credits(1) != queue_depth) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic wait_irq(input logic level, input string what);
    int n;
    n = 0;
    while (irq !== level && n < 8) begin
      @(posedge clk);
      #2;
      n++;
    end
    check(irq === level, what);
  endtask

  task automatic test_reset();
    check(gpio_out_en == '0 && gpio_out_val == '0 && irq == 1'b0, "outputs not low after reset");
    // Burst of queue_depth reads per host spends every initial credit
    for (int h = 0; h < 2; h++) begin
      for (int i = 0; i < queue_depth / 2; i++) begin
        read_reg(h, reg_gpio_dir, '0);
        read_reg(h, reg_gpio_out, '0);
      end
    end
    wait_idle();
  endtask

  task automatic test_registers();
    cur_dir = 8'($urandom);
    cur_out = 8'($urandom);
    write_reg(0, reg_gpio_dir, {24'($urandom), cur_dir});  // Upper bits must not stick
    write_reg(0, reg_gpio_out, {24'($urandom), cur_out});
    wait_idle();
    check(gpio_out_en == cur_dir && gpio_out_val == cur_out, "pin controls differ from writes");
    for (int h = 0; h < 2; h++) begin
      read_reg(h, reg_gpio_dir, 32'(cur_dir));
      read_reg(h, reg_gpio_out, 32'(cur_out));
    end
    wait_idle();
  endtask

  task automatic test_input_path();
    pin_val = 8'($urandom);
    cur_dir = 8'($urandom);
    write_reg(0, reg_gpio_dir, 32'(cur_dir));
    wait_idle();
    read_reg(1, reg_gpio_in, 32'((cur_dir & cur_out) | (~cur_dir & pin_val)));
    wait_idle();
  endtask

  task automatic test_edge_capture();
    pin_val = '0;
    write_reg(0, reg_gpio_dir, '0);  // All pins from the pad model
    write_reg(0, reg_edge_mask, 32'h04);
    read_reg(0, reg_edge_status, '0);
    wait_idle();
    pin_val = 8'h24;  // Pin 2 masked, pin 5 not
    wait_irq(1'b1, "irq did not rise on a masked edge");
    read_reg(1, reg_edge_status, 32'h04);
    write_reg(1, reg_edge_status, 32'h04);
    wait_idle();
    wait_irq(1'b0, "irq did not fall after the flag was cleared");
    read_reg(0, reg_edge_status, '0);
    read_reg(0, reg_edge_mask, 32'h04);
    wait_idle();
  endtask

  // Write then read back, queue kept full by the credit loop
  task automatic host_pairs(input int h, input logic [addr_w-1:0] addr);
    logic [data_w-1:0] v;
    for (int i = 0; i < 3 * queue_depth; i++) begin
      v = $urandom;
      write_reg(h, addr, v);
      read_reg(h, addr, {24'h0, v[7:0]});
    end
  endtask

  task automatic test_contention();
    fork
      host_pairs(0, reg_gpio_out);
      host_pairs(1, reg_edge_mask);
    join
    wait_idle();
  endtask

  task automatic test_unmapped();
    read_reg(0, 5'd12, '0);
    read_reg(1, 5'd24, '0);
    read_reg(1, 5'd12, '0);
    wait_idle();
  endtask

  // Watchdog sized from the test count
  initial begin
    repeat (num_tests * 2000) @(posedge clk);
    stop_run("Timeout: the tests did not finish in time");
  end

  initial begin
    void'($urandom(30));
    {h0_req_valid, h0_req_addr, h0_req_wstrb, h0_req_wdata} = '0;
    {h1_req_valid, h1_req_addr, h1_req_wstrb, h1_req_wdata} = '0;
    pin_val = '0;
    sent = '{0, 0};
    returned = '{0, 0};
    rcvd = '{0, 0};
    @(posedge resetn);
    @(posedge clk);
    #2;
    test_reset();
    test_registers();
    test_input_path();
    test_edge_capture();
    test_contention();
    test_unmapped();
    $display("Done: no errors");
    $finish;
  end

endmodule

/* files.f */
gpio_pkg.sv
cmd_queue.sv
bus_interconnect.sv
gpio_port.sv
edge_capture.sv
gpio_subsys.sv
tb_clock_gen.sv
gpio_subsys_assertions.sv
gpio_subsys_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the GPIO subsystem testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module gpio_subsys_tb -f files.f -o sim_gpio &&
./obj_dir/sim_gpio || { echo "Simulation failed"; exit 1; }
